//--- all.f
+incdir+hdl
hdl/cm_rx_pkg.sv
hdl/cm_frame_ctrl.sv
hdl/qp_info_parser.sv
hdl/tx_meta_parser.sv
hdl/cm_commit.sv
hdl/udp_cm_rx.sv
dv/udp_cm_rx_tb.sv

//--- dv/udp_cm_rx_tb.sv
`default_nettype none

`include "cm_rx_macros.svh"

module udp_cm_rx_tb
    import cm_rx_pkg::*;
();

    localparam int NUM = 11;
    // outputs load on the edge after msg_done.
    localparam int PULSE_EDGE = 1;

    typedef struct packed {
        logic [15:0] port;
        logic [15:0] len;
        logic [3:0]  last_beat;
        logic        qp_v;
        logic        meta_v;
        logic        start;
    } vec_t;

    logic clk = 1'b0;
    logic rst;
    udp_hdr_t hdr;
    payload_t payload;
    logic payload_valid;
    logic payload_last;
    qp_info_t qp_info_out;
    logic qp_info_valid;
    tx_cmd_t tx_cmd;
    logic meta_valid;
    logic start_transfer;
    logic busy;

    vec_t tbl[NUM];
    string names[NUM];
    qp_info_t exp_qp[NUM];
    tx_cmd_t exp_cmd[NUM];
    logic [2:0] exp_pulses[NUM];
    int last_edge[NUM];
    int pending[$];
    logic [7:0] msg[64];
    logic [31:0] lfsr;
    qp_info_t pub_qp;
    tx_cmd_t pub_cmd;
    int cycle = 0;
    int checked = 0;

    udp_cm_rx u_dut (
        .clk            (clk),
        .rst            (rst),
        .hdr            (hdr),
        .payload        (payload),
        .payload_valid  (payload_valid),
        .payload_last   (payload_last),
        .qp_info_out    (qp_info_out),
        .qp_info_valid  (qp_info_valid),
        .tx_cmd         (tx_cmd),
        .meta_valid     (meta_valid),
        .start_transfer (start_transfer),
        .busy           (busy)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [511:0] exp,
                               input logic [511:0] act);
        if (act !== exp) begin
            fail_run($sformatf("MISMATCH %s expected %0h actual %0h", name, exp, act));
        end
    endtask

    // 32-bit fibonacci lfsr, taps 32 22 2 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_byte(output logic [7:0] b);
        for (int j = 0; j < 8; j++) begin
            b[j] = lfsr[31];
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // little-endian field of n bytes starting at message byte first.
    function automatic logic [63:0] le_field(input int first, input int n);
        logic [63:0] v;
        v = '0;
        for (int j = 0; j < n; j++) begin
            v[j*8 +: 8] = msg[first + j];
        end
        return v;
    endfunction

    function automatic qp_info_t decode_qp();
        qp_info_t q;
        q.valid          = msg[0][0];
        q.req_type       = msg[0][7:1];
        q.loc_qpn        = qpn_t'(le_field(1, 3));
        q.loc_psn        = psn_t'(le_field(5, 3));
        q.loc_r_key      = r_key_t'(le_field(9, 4));
        q.loc_base_addr  = le_field(13, 8);
        q.loc_ip_addr    = ipv4_t'(le_field(21, 4));
        q.rem_qpn        = qpn_t'(le_field(25, 3));
        q.rem_psn        = psn_t'(le_field(29, 3));
        q.rem_r_key      = r_key_t'(le_field(33, 4));
        q.rem_base_addr  = le_field(37, 8);
        q.rem_ip_addr    = ipv4_t'(le_field(45, 4));
        q.listening_port = udp_port_t'(le_field(49, 2));
        return q;
    endfunction

    function automatic tx_cmd_t decode_cmd();
        tx_cmd_t c;
        c.valid        = msg[51][0];
        c.start        = msg[51][1];
        c.is_immediate = msg[51][2];
        c.tx_type      = msg[51][3];
        c.loc_qpn      = qpn_t'(le_field(25, 3));
        c.dma_length   = xfer_len_t'(le_field(52, 4));
        c.n_transfers  = xfer_len_t'(le_field(56, 4));
        return c;
    endfunction

    task automatic set_entry(input int i, input string name, input logic [15:0] port,
                             input logic [15:0] len, input int last_beat,
                             input logic qp_v, input logic meta_v, input logic start);
        names[i] = name;
        tbl[i] = '{port, len, 4'(last_beat), qp_v, meta_v, start};
    endtask

    task automatic fill_table();
        set_entry(0, "good_both", `CM_LISTEN_PORT, `CM_UDP_LEN, 7, 1, 1, 1);
        set_entry(1, "good_no_start", `CM_LISTEN_PORT, `CM_UDP_LEN, 7, 1, 1, 0);
        set_entry(2, "qp_clear", `CM_LISTEN_PORT, `CM_UDP_LEN, 7, 0, 1, 1);
        set_entry(3, "meta_clear_start_set", `CM_LISTEN_PORT, `CM_UDP_LEN, 7, 1, 0, 1);
        set_entry(4, "wrong_port", 16'h1234, `CM_UDP_LEN, 7, 1, 1, 1);
        set_entry(5, "wrong_len", `CM_LISTEN_PORT, 16'd80, 7, 1, 1, 1);
        set_entry(6, "last_on_beat5", `CM_LISTEN_PORT, `CM_UDP_LEN, 5, 1, 1, 1);
        set_entry(7, "last_on_beat9", `CM_LISTEN_PORT, `CM_UDP_LEN, 9, 1, 1, 1);
        // index wraps back to 7 on the last beat.
        set_entry(8, "last_on_beat15", `CM_LISTEN_PORT, `CM_UDP_LEN, 15, 1, 1, 1);
        set_entry(9, "good_after_bad", `CM_LISTEN_PORT, `CM_UDP_LEN, 7, 1, 1, 1);
        set_entry(10, "back_to_back", `CM_LISTEN_PORT, `CM_UDP_LEN, 7, 1, 1, 0);
    endtask

    // header strobe, then beats; returns one time unit after the last beat's edge.
    task automatic send_frame(input int i, input logic accepted);
        hdr.valid     = 1'b1;
        hdr.dest_port = tbl[i].port;
        hdr.length    = tbl[i].len;
        @(posedge clk);
        #1;
        hdr = '0;
        for (int b = 0; b <= int'(tbl[i].last_beat); b++) begin
            for (int l = 0; l < 8; l++) begin
                payload[l*8 +: 8] = msg[(b*8 + l) % 64];
            end
            payload_valid = 1'b1;
            payload_last  = (b == int'(tbl[i].last_beat));
            check_value({names[i], " busy"}, accepted, busy);
            @(posedge clk);
            #1;
        end
        payload_valid = 1'b0;
        payload_last  = 1'b0;
        last_edge[i]  = cycle;
        pending.push_back(i);
    endtask

    initial begin
        logic accepted;
        logic good;
        int t;
        rst           = 1'b1;
        hdr           = '0;
        payload       = '0;
        payload_valid = 1'b0;
        payload_last  = 1'b0;
        lfsr          = 32'd94509;
        fill_table();
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        check_value("reset busy", 0, busy);
        check_value("reset pulses", 0, {qp_info_valid, meta_valid, start_transfer});
        for (int i = 0; i < NUM; i++) begin
            for (int k = 0; k < 64; k++) begin
                random_byte(msg[k]);
            end
            msg[0][0]  = tbl[i].qp_v;
            msg[51][0] = tbl[i].meta_v;
            msg[51][1] = tbl[i].start;
            accepted = (tbl[i].port == `CM_LISTEN_PORT) && (tbl[i].len == `CM_UDP_LEN);
            good = accepted && (tbl[i].last_beat == 4'd7);
            // records stay at the last published value unless this one commits.
            if (good && tbl[i].qp_v) begin
                pub_qp = decode_qp();
            end
            if (good && tbl[i].meta_v) begin
                pub_cmd = decode_cmd();
            end
            exp_qp[i]     = pub_qp;
            exp_cmd[i]    = pub_cmd;
            exp_pulses[i] = {good && tbl[i].qp_v, good && tbl[i].meta_v,
                             good && tbl[i].meta_v && tbl[i].start};
            send_frame(i, accepted);
        end
        t = 0;
        while (checked < NUM) begin
            @(posedge clk);
            t++;
            if (t > 100) begin
                fail_run("timeout waiting for the last frame to be checked");
            end
        end
        $display("All checks passed");
        $finish;
    end

    // counts output pulses in a window after each frame's last beat.
    initial begin
        int i;
        int t;
        int k;
        int n_qp;
        int n_meta;
        int n_start;
        for (int e = 0; e < NUM; e++) begin
            t = 0;
            while (pending.size() == 0) begin
                @(negedge clk);
                t++;
                if (t > 100) begin
                    fail_run("timeout waiting for a frame to be sent");
                end
            end
            i = pending.pop_front();
            n_qp    = 0;
            n_meta  = 0;
            n_start = 0;
            while (cycle < last_edge[i] + 4) begin
                @(negedge clk);
                k = cycle - last_edge[i];
                if (qp_info_valid) begin
                    n_qp++;
                    check_value({names[i], " qp_info_valid edge"}, PULSE_EDGE, k);
                end
                if (meta_valid) begin
                    n_meta++;
                    check_value({names[i], " meta_valid edge"}, PULSE_EDGE, k);
                end
                if (start_transfer) begin
                    n_start++;
                    check_value({names[i], " start_transfer edge"}, PULSE_EDGE, k);
                end
            end
            check_value({names[i], " qp_info_valid pulses"}, exp_pulses[i][2], n_qp);
            check_value({names[i], " meta_valid pulses"}, exp_pulses[i][1], n_meta);
            check_value({names[i], " start_transfer pulses"}, exp_pulses[i][0], n_start);
            check_value({names[i], " qp_info_out"}, exp_qp[i], qp_info_out);
            check_value({names[i], " tx_cmd"}, exp_cmd[i], tx_cmd);
            if (exp_pulses[i][2] && exp_pulses[i][1]) begin
                check_value({names[i], " loc_qpn"}, exp_qp[i].rem_qpn, tx_cmd.loc_qpn);
            end
            checked++;
        end
    end

endmodule

`default_nettype wire

//--- hdl/cm_commit.sv
`default_nettype none

module cm_commit
    import cm_rx_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     msg_done,
    input  qp_info_t qp_info,
    input  tx_meta_t tx_meta,
    output qp_info_t qp_info_out,
    output logic     qp_info_valid,
    output tx_cmd_t  tx_cmd,
    output logic     meta_valid,
    output logic     start_transfer
);

    logic    qp_commit;
    logic    meta_commit;
    tx_cmd_t tx_cmd_next;

    // each record is published only if its own valid flag is set.
    assign qp_commit   = msg_done && qp_info.valid;
    assign meta_commit = msg_done && tx_meta.valid;

    // transfers run on the peer's queue pair.
    always_comb begin
        tx_cmd_next.valid        = tx_meta.valid;
        tx_cmd_next.start        = tx_meta.start;
        tx_cmd_next.is_immediate = tx_meta.is_immediate;
        tx_cmd_next.tx_type      = tx_meta.tx_type;
        tx_cmd_next.loc_qpn      = qp_info.rem_qpn;
        tx_cmd_next.dma_length   = tx_meta.dma_length;
        tx_cmd_next.n_transfers  = tx_meta.n_transfers;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            qp_info_valid  <= 1'b0;
            meta_valid     <= 1'b0;
            start_transfer <= 1'b0;
        end else begin
            qp_info_valid  <= qp_commit;
            meta_valid     <= meta_commit;
            start_transfer <= meta_commit && tx_meta.start;
        end
    end

    // records hold their last published value otherwise.
    always_ff @(posedge clk) begin
        if (qp_commit) begin
            qp_info_out <= qp_info;
        end
        if (meta_commit) begin
            tx_cmd <= tx_cmd_next;
        end
    end

endmodule

`default_nettype wire

//--- hdl/cm_frame_ctrl.sv
`default_nettype none

`include "cm_rx_macros.svh"

module cm_frame_ctrl
    import cm_rx_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  udp_hdr_t  hdr,
    input  logic      payload_valid,
    input  logic      payload_last,
    output logic      beat_take,
    output beat_idx_t beat_idx,
    output logic      msg_done,
    output logic      busy
);

    localparam beat_idx_t LAST_IDX = beat_idx_t'(`CM_BEATS - 1);

    cm_state_e state;
    logic      wrapped;
    logic      hdr_ok;
    logic      exact_end;

    // only our port, and only a datagram that holds exactly one message.
    assign hdr_ok = hdr.valid
                 && hdr.dest_port == `CM_LISTEN_PORT
                 && hdr.length == udp_len_t'(`CM_UDP_LEN);

    // every beat is taken while a message is open.
    assign beat_take = (state == read_msg) && payload_valid;

    assign busy = (state == read_msg);

    // last on the eighth beat of a frame that never wrapped.
    assign exact_end = payload_last && (beat_idx == LAST_IDX) && !wrapped;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= idle;
            beat_idx <= '0;
            wrapped  <= 1'b0;
            msg_done <= 1'b0;
        end else begin
            msg_done <= 1'b0;
            case (state)
                idle: begin
                    if (hdr_ok) begin
                        state    <= read_msg;
                        beat_idx <= '0;
                        wrapped  <= 1'b0;
                    end
                end
                read_msg: begin
                    if (beat_take) begin
                        beat_idx <= beat_idx + 1'b1;
                        if (payload_last) begin
                            state    <= idle;
                            msg_done <= exact_end;
                        end else if (beat_idx == LAST_IDX) begin
                            // a ninth beat follows, frame is too long.
                            wrapped <= 1'b1;
                        end
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/cm_rx_macros.svh
`ifndef CM_RX_MACROS_SVH
`define CM_RX_MACROS_SVH

// payload stream width, one 64-bit word per beat.
`define CM_DATA_WIDTH 64

// bytes carried by each payload beat.
`define CM_BYTE_LANES (`CM_DATA_WIDTH / 8)

// connection message size in bytes.
`define CM_MSG_BYTES 64

// beats needed for one full message.
`define CM_BEATS (`CM_MSG_BYTES / `CM_BYTE_LANES)

// udp length field: 8-byte udp header plus the message.
`define CM_UDP_LEN (8 + `CM_MSG_BYTES)

// destination port the connection manager listens on.
`define CM_LISTEN_PORT 16'h4321

`endif

//--- hdl/cm_rx_pkg.sv
`default_nettype none

`include "cm_rx_macros.svh"

package cm_rx_pkg;

    typedef logic [`CM_DATA_WIDTH-1:0]     payload_t;
    typedef logic [15:0]                   udp_port_t;
    typedef logic [15:0]                   udp_len_t;
    typedef logic [$clog2(`CM_BEATS)-1:0]  beat_idx_t;
    typedef logic [6:0]                    req_type_t;
    typedef logic [23:0]                   qpn_t;
    typedef logic [23:0]                   psn_t;
    typedef logic [31:0]                   r_key_t;
    typedef logic [63:0]                   vaddr_t;
    typedef logic [31:0]                   ipv4_t;
    typedef logic [31:0]                   xfer_len_t;

    // one strobe per incoming datagram.
    typedef struct packed {
        logic      valid;
        udp_port_t dest_port;
        udp_len_t  length;
    } udp_hdr_t;

    typedef struct packed {
        logic      valid;
        req_type_t req_type;
        qpn_t      loc_qpn;
        psn_t      loc_psn;
        r_key_t    loc_r_key;
        vaddr_t    loc_base_addr;
        ipv4_t     loc_ip_addr;
        qpn_t      rem_qpn;
        psn_t      rem_psn;
        r_key_t    rem_r_key;
        vaddr_t    rem_base_addr;
        ipv4_t     rem_ip_addr;
        udp_port_t listening_port;
    } qp_info_t;

    typedef struct packed {
        logic      valid;
        logic      start;
        logic      is_immediate;
        logic      tx_type;
        xfer_len_t dma_length;
        xfer_len_t n_transfers;
    } tx_meta_t;

    // metadata as published, tagged with the queue pair it targets.
    typedef struct packed {
        logic      valid;
        logic      start;
        logic      is_immediate;
        logic      tx_type;
        qpn_t      loc_qpn;
        xfer_len_t dma_length;
        xfer_len_t n_transfers;
    } tx_cmd_t;

    typedef enum logic {
        idle,
        read_msg
    } cm_state_e;

endpackage

`default_nettype wire

//--- hdl/qp_info_parser.sv
`default_nettype none

`include "cm_rx_macros.svh"

module qp_info_parser
    import cm_rx_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      beat_take,
    input  beat_idx_t beat_idx,
    input  payload_t  payload,
    output qp_info_t  qp_info
);

    localparam int QP_BYTES = 51;
    localparam int LANE_W   = $clog2(`CM_BYTE_LANES);
    localparam int MSG_W    = $clog2(`CM_MSG_BYTES);

    // message bytes 0 to 50, byte k at bits 8k+7:8k.
    logic [QP_BYTES*8-1:0] qp_bytes;
    logic [QP_BYTES*8-1:0] qp_bytes_next;

    // true for message bytes that carry a connection-info field.
    function automatic logic is_qp_byte(input logic [MSG_W-1:0] k);
        return (k < QP_BYTES) && (k != 4) && (k != 8) && (k != 28) && (k != 32);
    endfunction

    always_comb begin
        logic [MSG_W-1:0] k;
        qp_bytes_next = qp_bytes;
        for (int lane = 0; lane < `CM_BYTE_LANES; lane++) begin
            k = {beat_idx, LANE_W'(lane)};
            if (beat_take && is_qp_byte(k)) begin
                qp_bytes_next[k*8 +: 8] = payload[lane*8 +: 8];
            end
        end
    end

    // bit 0 is the qp valid flag.
    always_ff @(posedge clk) begin
        if (rst) begin
            qp_bytes[0] <= 1'b0;
        end else begin
            qp_bytes <= qp_bytes_next;
        end
    end

    assign qp_info.valid          = qp_bytes[0];
    assign qp_info.req_type       = qp_bytes[7:1];
    assign qp_info.loc_qpn        = qp_bytes[8*1  +: 24];
    assign qp_info.loc_psn        = qp_bytes[8*5  +: 24];
    assign qp_info.loc_r_key      = qp_bytes[8*9  +: 32];
    assign qp_info.loc_base_addr  = qp_bytes[8*13 +: 64];
    assign qp_info.loc_ip_addr    = qp_bytes[8*21 +: 32];
    assign qp_info.rem_qpn        = qp_bytes[8*25 +: 24];
    assign qp_info.rem_psn        = qp_bytes[8*29 +: 24];
    assign qp_info.rem_r_key      = qp_bytes[8*33 +: 32];
    assign qp_info.rem_base_addr  = qp_bytes[8*37 +: 64];
    assign qp_info.rem_ip_addr    = qp_bytes[8*45 +: 32];
    assign qp_info.listening_port = qp_bytes[8*49 +: 16];

endmodule

`default_nettype wire

//--- hdl/tx_meta_parser.sv
`default_nettype none

`include "cm_rx_macros.svh"

module tx_meta_parser
    import cm_rx_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      beat_take,
    input  beat_idx_t beat_idx,
    input  payload_t  payload,
    output tx_meta_t  tx_meta
);

    localparam int FLAG_BYTE = 51;
    localparam int DMA_BYTE  = 52;
    localparam int NTR_BYTE  = 56;

    localparam beat_idx_t FLAG_BEAT = beat_idx_t'(FLAG_BYTE / `CM_BYTE_LANES);
    localparam beat_idx_t DMA_BEAT  = beat_idx_t'(DMA_BYTE / `CM_BYTE_LANES);
    localparam beat_idx_t NTR_BEAT  = beat_idx_t'(NTR_BYTE / `CM_BYTE_LANES);

    localparam int FLAG_LANE = FLAG_BYTE % `CM_BYTE_LANES;
    localparam int DMA_LANE  = DMA_BYTE % `CM_BYTE_LANES;
    localparam int NTR_LANE  = NTR_BYTE % `CM_BYTE_LANES;

    // tx_type, is_immediate, start, valid from msb down.
    logic [3:0] flags;

    always_ff @(posedge clk) begin
        if (rst) begin
            flags <= '0;
        end else if (beat_take && beat_idx == FLAG_BEAT) begin
            flags <= payload[FLAG_LANE*8 +: 4];
        end
    end

    always_ff @(posedge clk) begin
        if (beat_take && beat_idx == DMA_BEAT) begin
            tx_meta.dma_length <= payload[DMA_LANE*8 +: 32];
        end
        if (beat_take && beat_idx == NTR_BEAT) begin
            tx_meta.n_transfers <= payload[NTR_LANE*8 +: 32];
        end
    end

    assign tx_meta.valid        = flags[0];
    assign tx_meta.start        = flags[1];
    assign tx_meta.is_immediate = flags[2];
    assign tx_meta.tx_type      = flags[3];

endmodule

`default_nettype wire

//--- hdl/udp_cm_rx.sv
`default_nettype none

module udp_cm_rx
    import cm_rx_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  udp_hdr_t hdr,
    input  payload_t payload,
    input  logic     payload_valid,
    input  logic     payload_last,
    output qp_info_t qp_info_out,
    output logic     qp_info_valid,
    output tx_cmd_t  tx_cmd,
    output logic     meta_valid,
    output logic     start_transfer,
    output logic     busy
);

    logic      beat_take;
    beat_idx_t beat_idx;
    logic      msg_done;
    qp_info_t  qp_info;
    tx_meta_t  tx_meta;

    cm_frame_ctrl u_frame_ctrl (
        .clk           (clk),
        .rst           (rst),
        .hdr           (hdr),
        .payload_valid (payload_valid),
        .payload_last  (payload_last),
        .beat_take     (beat_take),
        .beat_idx      (beat_idx),
        .msg_done      (msg_done),
        .busy          (busy)
    );

    // both parsers see every taken beat.
    qp_info_parser u_qp_info_parser (
        .clk       (clk),
        .rst       (rst),
        .beat_take (beat_take),
        .beat_idx  (beat_idx),
        .payload   (payload),
        .qp_info   (qp_info)
    );

    tx_meta_parser u_tx_meta_parser (
        .clk       (clk),
        .rst       (rst),
        .beat_take (beat_take),
        .beat_idx  (beat_idx),
        .payload   (payload),
        .tx_meta   (tx_meta)
    );

    cm_commit u_commit (
        .clk            (clk),
        .rst            (rst),
        .msg_done       (msg_done),
        .qp_info        (qp_info),
        .tx_meta        (tx_meta),
        .qp_info_out    (qp_info_out),
        .qp_info_valid  (qp_info_valid),
        .tx_cmd         (tx_cmd),
        .meta_valid     (meta_valid),
        .start_transfer (start_transfer)
    );

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter the project root"
    exit 1
fi

verilator --binary --timing -Wno-fatal -f all.f --top-module udp_cm_rx_tb -o udp_cm_rx_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/udp_cm_rx_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0
